// File: hw/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// buffer sizes
`define ROB_DEPTH 8
`define RS_DEPTH 4

// architectural register file
`define NUM_REGS 16

// rob tag width, log2 of ROB_DEPTH
`define TAG_W 3

// opcode field encodings, inst[15:12]
`define OP_NOP 4'd0
`define OP_ALU 4'd1
`define OP_LOAD 4'd2
`define OP_STORE 4'd3
`define OP_BRANCH 4'd4

`endif

// File: hw/ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

    typedef logic [`TAG_W-1:0] rob_tag_t;              // rob index
    typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;   // architectural register
    typedef logic [3:0] opcode_t;
    typedef logic [15:0] inst_word_t;                  // op | rd | rs1 | rs2

    typedef enum logic [1:0] {
        RS_FREE,
        RS_WAITING,
        RS_READY
    } rs_state_t;

    typedef struct packed {
        logic       valid;
        inst_word_t inst;
    } if_id_packet_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     has_rd;
        logic     rd_mem;     // load
        logic     wr_mem;     // store
        logic     is_branch;
    } id_packet_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        logic     mispredict;   // only meaningful for branches
    } cdb_packet_t;

    typedef struct packed {
        logic     src1_pending;
        rob_tag_t src1_tag;
        logic     src2_pending;
        rob_tag_t src2_tag;
    } mt2rs_packet_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        rob_tag_t tag;      // new producer of rd
    } rs2mt_packet_t;

    typedef struct packed {
        rob_tag_t tail_tag;   // tag given to the next dispatch
        rob_tag_t head_tag;   // oldest in-flight tag, for issue age
        logic     squash;
    } rob2rs_packet_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t rd;
    } rob2mt_packet_t;

    typedef struct packed {
        logic     valid;
        opcode_t  opcode;
        rob_tag_t dst_tag;
        rob_tag_t src1_tag;
        rob_tag_t src2_tag;
    } is_packet_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     has_rd;
        rob_tag_t tag;
    } rob_retire_packet_t;

endpackage

// File: hw/decode_stage.sv
`include "ooo_consts.svh"

module decode_stage import ooo_pkg::*; (
    input  if_id_packet_t id_in,
    output id_packet_t    id_out
);

    always_comb begin
        id_out = '0;
        id_out.valid = id_in.valid;
        id_out.rd = id_in.inst[11:8];
        id_out.rs1 = id_in.inst[7:4];
        id_out.rs2 = id_in.inst[3:0];

        case (id_in.inst[15:12])
            `OP_ALU: begin
                id_out.opcode = `OP_ALU;
                id_out.has_rd = 1'b1;
            end
            `OP_LOAD: begin
                id_out.opcode = `OP_LOAD;
                id_out.has_rd = 1'b1;
                id_out.rd_mem = 1'b1;
            end
            `OP_STORE: begin
                id_out.opcode = `OP_STORE;
                id_out.wr_mem = 1'b1;
            end
            `OP_BRANCH: begin
                id_out.opcode = `OP_BRANCH;
                id_out.is_branch = 1'b1;
            end
            default: begin
                id_out.opcode = `OP_NOP;   // unknown opcodes fall here too
            end
        endcase
    end

endmodule

// File: hw/map_table.sv
`include "ooo_consts.svh"

module map_table import ooo_pkg::*; (
    input  logic           clock,
    input  logic           rst,
    input  logic           squash,
    input  logic           dispatch_en,
    input  id_packet_t     id_in,
    input  rs2mt_packet_t  rs2mt_in,
    input  cdb_packet_t    cdb_in,
    input  rob2mt_packet_t rob2mt_in,
    output mt2rs_packet_t  mt2rs_out
);

    logic     pending [`NUM_REGS];
    rob_tag_t tag_q   [`NUM_REGS];

    // source lookup, a result on the cdb this cycle counts as available
    always_comb begin
        mt2rs_out.src1_tag = tag_q[id_in.rs1];
        mt2rs_out.src2_tag = tag_q[id_in.rs2];
        mt2rs_out.src1_pending = pending[id_in.rs1] &&
            !(cdb_in.valid && cdb_in.tag == tag_q[id_in.rs1]);
        mt2rs_out.src2_pending = pending[id_in.rs2] &&
            !(cdb_in.valid && cdb_in.tag == tag_q[id_in.rs2]);
    end

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                pending[r] <= 1'b0;
            end
        end else begin
            for (int r = 0; r < `NUM_REGS; r++) begin
                if (cdb_in.valid && tag_q[r] == cdb_in.tag) begin
                    pending[r] <= 1'b0;   // result broadcast
                end
            end
            // only clear if no younger writer took over the register
            if (rob2mt_in.valid && tag_q[rob2mt_in.rd] == rob2mt_in.tag) begin
                pending[rob2mt_in.rd] <= 1'b0;
            end
            if (dispatch_en && rs2mt_in.valid) begin
                pending[rs2mt_in.rd] <= 1'b1;   // new producer wins over clears
                tag_q[rs2mt_in.rd] <= rs2mt_in.tag;
            end
        end
    end

    // the tag handed to a new producer is free, so no result can carry it yet
    new_tag_not_on_cdb: assert property (@(posedge clock) disable iff (rst)
        (dispatch_en && rs2mt_in.valid && cdb_in.valid) |-> cdb_in.tag != rs2mt_in.tag)
        else $error("map_table: cdb carries the tag being dispatched");

endmodule

// File: hw/reservation_station.sv
`include "ooo_consts.svh"

module reservation_station import ooo_pkg::*; (
    input  logic           clock,
    input  logic           rst,
    input  logic           squash,
    input  logic           dispatch_en,
    input  logic           is_stall,
    input  id_packet_t     id_in,
    input  mt2rs_packet_t  mt2rs_in,
    input  rob2rs_packet_t rob2rs_in,
    input  cdb_packet_t    cdb_in,
    output rs2mt_packet_t  rs2mt_out,
    output is_packet_t     is_out,
    output logic           full
);

    typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;

    rs_state_t state   [`RS_DEPTH];
    opcode_t   op_q    [`RS_DEPTH];
    rob_tag_t  dst_q   [`RS_DEPTH];
    rob_tag_t  s1_tag  [`RS_DEPTH];
    rob_tag_t  s2_tag  [`RS_DEPTH];
    logic      s1_pend [`RS_DEPTH];
    logic      s2_pend [`RS_DEPTH];

    logic    accept;
    logic    free_found;
    rs_idx_t free_idx;
    logic    iss_found;
    rs_idx_t iss_idx;
    logic    issue_now;

    // stores and nops never occupy an entry
    assign accept = dispatch_en && id_in.opcode != `OP_NOP && !id_in.wr_mem;
    assign issue_now = iss_found && !is_stall;

    assign rs2mt_out.valid = accept && id_in.has_rd;
    assign rs2mt_out.rd = id_in.rd;
    assign rs2mt_out.tag = rob2rs_in.tail_tag;

    // lowest free entry
    always_comb begin
        free_found = 1'b0;
        free_idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == RS_FREE) begin
                free_found = 1'b1;
                free_idx = rs_idx_t'(i);
            end
        end
    end

    assign full = !free_found;

    // oldest ready entry, age measured from the rob head
    always_comb begin
        rob_tag_t age;
        rob_tag_t best_age;
        iss_found = 1'b0;
        iss_idx = '0;
        best_age = '1;
        for (int i = 0; i < `RS_DEPTH; i++) begin
            age = dst_q[i] - rob2rs_in.head_tag;
            if (state[i] == RS_READY && (!iss_found || age < best_age)) begin
                iss_found = 1'b1;
                iss_idx = rs_idx_t'(i);
                best_age = age;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                state[i] <= RS_FREE;
            end
            is_out.valid <= 1'b0;
        end else begin
            // tag capture from the cdb
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (state[i] == RS_WAITING) begin
                    if (cdb_in.valid && s1_tag[i] == cdb_in.tag) s1_pend[i] <= 1'b0;
                    if (cdb_in.valid && s2_tag[i] == cdb_in.tag) s2_pend[i] <= 1'b0;
                    if ((!s1_pend[i] || (cdb_in.valid && s1_tag[i] == cdb_in.tag)) &&
                        (!s2_pend[i] || (cdb_in.valid && s2_tag[i] == cdb_in.tag))) begin
                        state[i] <= RS_READY;
                    end
                end
            end

            if (accept) begin
                op_q[free_idx] <= id_in.opcode;
                dst_q[free_idx] <= rob2rs_in.tail_tag;
                s1_tag[free_idx] <= mt2rs_in.src1_tag;
                s2_tag[free_idx] <= mt2rs_in.src2_tag;
                s1_pend[free_idx] <= mt2rs_in.src1_pending;
                s2_pend[free_idx] <= mt2rs_in.src2_pending;
                state[free_idx] <= (mt2rs_in.src1_pending || mt2rs_in.src2_pending) ?
                    RS_WAITING : RS_READY;
            end

            is_out.valid <= issue_now;
            is_out.opcode <= op_q[iss_idx];
            is_out.dst_tag <= dst_q[iss_idx];
            is_out.src1_tag <= s1_tag[iss_idx];
            is_out.src2_tag <= s2_tag[iss_idx];
            if (issue_now) state[iss_idx] <= RS_FREE;
        end
    end

    // a dispatch into the station always finds a free entry
    accept_has_room: assert property (@(posedge clock) disable iff (rst)
        accept |-> free_found)
        else $error("reservation_station: dispatch into a full station");

endmodule

// File: hw/reorder_buffer.sv
`include "ooo_consts.svh"

module reorder_buffer import ooo_pkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               dispatch_en,
    input  logic               store_done,
    input  id_packet_t         id_in,
    input  cdb_packet_t        cdb_in,
    output rob2rs_packet_t     rob2rs_out,
    output rob2mt_packet_t     rob2mt_out,
    output rob_retire_packet_t retire_out,
    output logic               store_start,
    output logic               full
);

    logic     valid_q    [`ROB_DEPTH];
    logic     done_q     [`ROB_DEPTH];
    logic     mispred_q  [`ROB_DEPTH];
    logic     is_store_q [`ROB_DEPTH];
    logic     is_br_q    [`ROB_DEPTH];
    logic     has_rd_q   [`ROB_DEPTH];
    reg_idx_t rd_q       [`ROB_DEPTH];

    rob_tag_t         head;
    rob_tag_t         tail;
    logic [`TAG_W:0]  count;
    logic             squash;
    logic             store_sent;   // store_start already given for the head
    logic             retire_now;

    assign full = count == `ROB_DEPTH;
    assign retire_now = valid_q[head] && done_q[head] && !squash;

    assign rob2rs_out.tail_tag = tail;
    assign rob2rs_out.head_tag = head;
    assign rob2rs_out.squash = squash;

    // map table clear, same edge as retire
    assign rob2mt_out.valid = retire_now && has_rd_q[head];
    assign rob2mt_out.tag = head;
    assign rob2mt_out.rd = rd_q[head];

    always_ff @(posedge clock) begin
        if (rst || squash) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                valid_q[i] <= 1'b0;
            end
            head <= '0;
            tail <= '0;
            count <= '0;
            squash <= 1'b0;
            store_sent <= 1'b0;
            store_start <= 1'b0;
            retire_out.valid <= 1'b0;
        end else begin
            if (dispatch_en) begin
                valid_q[tail] <= 1'b1;
                done_q[tail] <= id_in.opcode == `OP_NOP;   // nothing to wait for
                mispred_q[tail] <= 1'b0;
                is_store_q[tail] <= id_in.wr_mem;
                is_br_q[tail] <= id_in.is_branch;
                has_rd_q[tail] <= id_in.has_rd;
                rd_q[tail] <= id_in.rd;
                tail <= tail + 1'b1;
            end

            if (cdb_in.valid) begin
                done_q[cdb_in.tag] <= 1'b1;
                mispred_q[cdb_in.tag] <= cdb_in.mispredict && is_br_q[cdb_in.tag];
            end

            if (store_done && valid_q[head] && is_store_q[head]) begin
                done_q[head] <= 1'b1;
            end

            // one pulse per store at the head
            store_start <= 1'b0;
            if (valid_q[head] && is_store_q[head] && !store_sent) begin
                store_start <= 1'b1;
                store_sent <= 1'b1;
            end

            retire_out.valid <= retire_now;
            retire_out.rd <= rd_q[head];
            retire_out.has_rd <= has_rd_q[head];
            retire_out.tag <= head;

            if (retire_now) begin
                valid_q[head] <= 1'b0;
                head <= head + 1'b1;
                store_sent <= 1'b0;
                squash <= mispred_q[head];   // flush at the following edge
            end

            count <= count + dispatch_en - retire_now;
        end
    end

    // functional units only broadcast tags of live, unfinished entries
    cdb_tag_live: assert property (@(posedge clock) disable iff (rst)
        cdb_in.valid |-> valid_q[cdb_in.tag] && !done_q[cdb_in.tag])
        else $error("reorder_buffer: cdb tag %0d not in flight", cdb_in.tag);

endmodule

// File: hw/dispatch_issue.sv
`include "ooo_consts.svh"

module dispatch_issue import ooo_pkg::*; (
    input  logic               clock,
    input  logic               rst,
    input  logic               stall,
    input  logic               is_stall,
    input  logic               load_done,
    input  logic               store_done,
    input  if_id_packet_t      if_id_in,
    input  cdb_packet_t        cdb_in,
    output is_packet_t         is_out,
    output rob_retire_packet_t retire_out,
    output logic               store_start,
    output logic               mem_busy,
    output logic               struc_hazard,
    output logic               squash
);

    id_packet_t     id_packet;
    mt2rs_packet_t  mt2rs;
    rs2mt_packet_t  rs2mt;
    rob2rs_packet_t rob2rs;
    rob2mt_packet_t rob2mt;

    logic rs_full;
    logic rob_full;
    logic needs_rs;
    logic is_mem;
    logic dispatch_en;

    assign squash = rob2rs.squash;

    assign needs_rs = id_packet.opcode != `OP_NOP && !id_packet.wr_mem;   // stores skip the rs
    assign is_mem = id_packet.rd_mem || id_packet.wr_mem;
    assign struc_hazard = rob_full || (rs_full && id_packet.valid && needs_rs);
    assign dispatch_en = id_packet.valid && !stall && !struc_hazard && !mem_busy && !squash;

    // one memory op in flight
    always_ff @(posedge clock) begin
        if (rst || squash) begin
            mem_busy <= 1'b0;
        end else if (dispatch_en && is_mem) begin
            mem_busy <= 1'b1;
        end else if (load_done || store_done) begin
            mem_busy <= 1'b0;
        end
    end

    decode_stage u_decode (
        .id_in  (if_id_in),
        .id_out (id_packet)
    );

    map_table u_map_table (
        .clock       (clock),
        .rst         (rst),
        .squash      (squash),
        .dispatch_en (dispatch_en),
        .id_in       (id_packet),
        .rs2mt_in    (rs2mt),
        .cdb_in      (cdb_in),
        .rob2mt_in   (rob2mt),
        .mt2rs_out   (mt2rs)
    );

    reservation_station u_rs (
        .clock       (clock),
        .rst         (rst),
        .squash      (squash),
        .dispatch_en (dispatch_en),
        .is_stall    (is_stall),
        .id_in       (id_packet),
        .mt2rs_in    (mt2rs),
        .rob2rs_in   (rob2rs),
        .cdb_in      (cdb_in),
        .rs2mt_out   (rs2mt),
        .is_out      (is_out),
        .full        (rs_full)
    );

    reorder_buffer u_rob (
        .clock       (clock),
        .rst         (rst),
        .dispatch_en (dispatch_en),
        .store_done  (store_done),
        .id_in       (id_packet),
        .cdb_in      (cdb_in),
        .rob2rs_out  (rob2rs),
        .rob2mt_out  (rob2mt),
        .retire_out  (retire_out),
        .store_start (store_start),
        .full        (rob_full)
    );

    // memory completion only for an op that is in flight
    mem_done_while_busy: assert property (@(posedge clock) disable iff (rst)
        (load_done || store_done) |-> mem_busy)
        else $error("dispatch_issue: memory done with no memory op in flight");

endmodule

// File: tb/dispatch_issue_tb.sv
`include "ooo_consts.svh"

module dispatch_issue_tb import ooo_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_TESTS = 6;

    logic               clock;
    logic               rst;
    logic               stall;
    logic               is_stall;
    logic               load_done;
    logic               store_done;
    if_id_packet_t      if_id_in;
    cdb_packet_t        cdb_in;
    is_packet_t         is_out;
    rob_retire_packet_t retire_out;
    logic               store_start;
    logic               mem_busy;
    logic               struc_hazard;
    logic               squash;

    // reference copy of one rob slot
    typedef struct packed {
        opcode_t  op;
        reg_idx_t rd;
        logic     has_rd;
        logic     done;
        logic     mispred;
        logic     issued;
        logic     start_sent;
        logic     p1;         // rs1 was pending at dispatch
        logic     w1;         // still waiting on t1
        rob_tag_t t1;
        logic     p2;
        logic     w2;
        rob_tag_t t2;
    } rob_model_t;

    rob_model_t rob_m [`ROB_DEPTH];
    rob_tag_t   m_head;
    rob_tag_t   m_tail;
    int         m_cnt;
    int         rs_cnt;
    logic       m_mem_busy;
    logic       exp_squash;
    logic       prev_squash;     // squash level seen at the last edge
    logic       mp_pend [`NUM_REGS];
    rob_tag_t   mp_tag  [`NUM_REGS];
    rob_tag_t   exec_q [$];      // issued, waiting for a cdb slot
    inst_word_t prog [$];        // fetch queue, front is on if_id_in

    logic       drv_accept;
    rob_model_t drv_entry;
    int         store_wait;
    logic [31:0] lfsr;

    logic cdb_en;
    logic force_mispred;
    logic hold_is_stall;
    int   squash_count;
    int   store_count;
    int   load_count;
    int   squash_before;
    int   store_before;
    int   load_before;

    dispatch_issue u_dispatch_issue (
        .clock        (clock),
        .rst          (rst),
        .stall        (stall),
        .is_stall     (is_stall),
        .load_done    (load_done),
        .store_done   (store_done),
        .if_id_in     (if_id_in),
        .cdb_in       (cdb_in),
        .is_out       (is_out),
        .retire_out   (retire_out),
        .store_start  (store_start),
        .mem_busy     (mem_busy),
        .struc_hazard (struc_hazard),
        .squash       (squash)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            report_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h at time %0t",
                                     name, got, want, $time));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic needs_station(input opcode_t op);
        return op == `OP_ALU || op == `OP_LOAD || op == `OP_BRANCH;
    endfunction

    function automatic inst_word_t make_inst(input opcode_t op, input reg_idx_t rd,
                                             input reg_idx_t rs1, input reg_idx_t rs2);
        return {op, rd, rs1, rs2};
    endfunction

    task automatic flush_model();
        m_head = '0;
        m_tail = '0;
        m_cnt = 0;
        rs_cnt = 0;
        m_mem_busy = 1'b0;
        store_wait = 0;
        exec_q.delete();
        for (int r = 0; r < `NUM_REGS; r++) begin
            mp_pend[r] = 1'b0;
        end
    endtask

    // one cycle: check the last edge, update the reference, drive the next edge
    task automatic step();
        int       age;
        int       idx;
        rob_tag_t t;
        rob_tag_t oldest;
        logic     found_ready;
        logic     want_retire;
        logic     want_start;
        logic     want_hazard;
        opcode_t  op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        @(negedge clock);
        found_ready = 1'b0;
        oldest = '0;
        for (age = m_cnt - 1; age >= 0; age--) begin
            t = m_head + rob_tag_t'(age);
            if (needs_station(rob_m[t].op) && !rob_m[t].issued &&
                !rob_m[t].w1 && !rob_m[t].w2) begin
                found_ready = 1'b1;
                oldest = t;
            end
        end
        want_retire = m_cnt > 0 && rob_m[m_head].done && !prev_squash;
        want_start = m_cnt > 0 && rob_m[m_head].op == `OP_STORE && !rob_m[m_head].start_sent;

        check_value("is_out.valid", is_out.valid, found_ready && !is_stall);
        if (is_out.valid) begin
            check_value("is_out.dst_tag", is_out.dst_tag, oldest);
            check_value("is_out.opcode", is_out.opcode, rob_m[oldest].op);
            if (rob_m[oldest].p1) check_value("is_out.src1_tag", is_out.src1_tag, rob_m[oldest].t1);
            if (rob_m[oldest].p2) check_value("is_out.src2_tag", is_out.src2_tag, rob_m[oldest].t2);
            rob_m[oldest].issued = 1'b1;
            rs_cnt--;
            exec_q.push_back(oldest);
        end

        check_value("store_start", store_start, want_start);
        if (store_start) begin
            rob_m[m_head].start_sent = 1'b1;
            store_wait = 1 + int'(rand_bits(2));   // memory latency
            store_count++;
        end

        check_value("retire_out.valid", retire_out.valid, want_retire);
        exp_squash = 1'b0;
        if (retire_out.valid) begin
            check_value("retire_out.tag", retire_out.tag, m_head);
            check_value("retire_out.rd", retire_out.rd, rob_m[m_head].rd);
            check_value("retire_out.has_rd", retire_out.has_rd, rob_m[m_head].has_rd);
            t = m_head;
            if (rob_m[t].has_rd && mp_pend[rob_m[t].rd] && mp_tag[rob_m[t].rd] == t) begin
                mp_pend[rob_m[t].rd] = 1'b0;
            end
            exp_squash = rob_m[t].mispred;
            m_head = m_head + 1'b1;
            m_cnt--;
        end

        // results broadcast at the last edge
        if (cdb_in.valid) begin
            rob_m[cdb_in.tag].done = 1'b1;
            rob_m[cdb_in.tag].mispred = cdb_in.mispredict && rob_m[cdb_in.tag].op == `OP_BRANCH;
            for (int r = 0; r < `NUM_REGS; r++) begin
                if (mp_tag[r] == cdb_in.tag) mp_pend[r] = 1'b0;
            end
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (rob_m[i].w1 && rob_m[i].t1 == cdb_in.tag) rob_m[i].w1 = 1'b0;
                if (rob_m[i].w2 && rob_m[i].t2 == cdb_in.tag) rob_m[i].w2 = 1'b0;
            end
        end
        if (store_done) begin
            rob_m[m_head].done = 1'b1;
            m_mem_busy = 1'b0;
        end
        if (load_done) m_mem_busy = 1'b0;

        if (drv_accept) begin
            rob_m[m_tail] = drv_entry;
            if (needs_station(drv_entry.op)) rs_cnt++;
            if (drv_entry.has_rd) begin
                mp_pend[drv_entry.rd] = 1'b1;
                mp_tag[drv_entry.rd] = m_tail;
            end
            if (drv_entry.op == `OP_LOAD || drv_entry.op == `OP_STORE) m_mem_busy = 1'b1;
            m_tail = m_tail + 1'b1;
            m_cnt++;
            void'(prog.pop_front());
        end

        check_value("squash", squash, exp_squash);
        prev_squash = exp_squash;
        if (exp_squash) begin
            flush_model();   // window empties at the coming edge
            squash_count++;
        end else begin
            check_value("mem_busy", mem_busy, m_mem_busy);
        end

        // inputs for the coming edge
        cdb_in = '0;
        load_done = 1'b0;
        store_done = 1'b0;
        if (cdb_en && exec_q.size() > 0 && rand_bits(2) != 0) begin
            idx = int'(rand_bits(4)) % exec_q.size();
            t = exec_q[idx];
            exec_q.delete(idx);
            cdb_in.valid = 1'b1;
            cdb_in.tag = t;
            if (rob_m[t].op == `OP_BRANCH) begin
                cdb_in.mispredict = force_mispred || rand_bits(3) == 0;
            end
            if (rob_m[t].op == `OP_LOAD) begin
                load_done = 1'b1;
                load_count++;
            end
        end
        if (store_wait > 0) begin
            store_wait--;
            store_done = store_wait == 0;
        end
        is_stall = hold_is_stall ? 1'b1 : rand_bits(2) == 0;
        stall = rand_bits(3) == 0;

        if_id_in = '0;
        drv_entry = '0;
        if (prog.size() > 0) begin
            if_id_in.valid = 1'b1;
            if_id_in.inst = prog[0];
            op = prog[0][15:12];
            rs1 = prog[0][7:4];
            rs2 = prog[0][3:0];
            drv_entry.op = op;
            drv_entry.rd = prog[0][11:8];
            drv_entry.has_rd = op == `OP_ALU || op == `OP_LOAD;
            drv_entry.done = op == `OP_NOP;
            // a tag on the cdb this cycle is already available
            drv_entry.p1 = mp_pend[rs1] && !(cdb_in.valid && cdb_in.tag == mp_tag[rs1]);
            drv_entry.t1 = mp_tag[rs1];
            drv_entry.w1 = drv_entry.p1;
            drv_entry.p2 = mp_pend[rs2] && !(cdb_in.valid && cdb_in.tag == mp_tag[rs2]);
            drv_entry.t2 = mp_tag[rs2];
            drv_entry.w2 = drv_entry.p2;
        end
        want_hazard = m_cnt == `ROB_DEPTH ||
            (rs_cnt == `RS_DEPTH && if_id_in.valid && needs_station(drv_entry.op));
        drv_accept = if_id_in.valid && !stall && !want_hazard && !m_mem_busy && !exp_squash;
        #1;
        if (!exp_squash) check_value("struc_hazard", struc_hazard, want_hazard);
    endtask

    task automatic run_until_idle();
        while (prog.size() > 0 || m_cnt > 0) begin
            step();
        end
    endtask

    task automatic queue_random(input int n);
        logic [2:0] pick;
        opcode_t    op;
        for (int i = 0; i < n; i++) begin
            pick = rand_bits(3);
            case (pick)
                3'd0, 3'd1, 3'd2: op = `OP_ALU;
                3'd3: op = `OP_LOAD;
                3'd4: op = `OP_STORE;
                3'd5: op = `OP_BRANCH;
                default: op = `OP_NOP;
            endcase
            // registers 0 to 3 only, so dependencies are frequent
            prog.push_back(make_inst(op, rand_bits(2), rand_bits(2), rand_bits(2)));
        end
    endtask

    reset_leaves_outputs_low: assert property (@(posedge clock)
        rst |=> !is_out.valid && !retire_out.valid && !store_start && !squash &&
                !mem_busy && !struc_hazard)
        else report_failure("control outputs were not low after reset");

    no_issue_after_is_stall: assert property (@(posedge clock) disable iff (rst)
        is_stall |=> !is_out.valid)
        else report_failure("an instruction issued while is_stall was high");

    squash_is_pulse: assert property (@(posedge clock) disable iff (rst)
        squash |=> !squash)
        else report_failure("squash stayed high for more than one cycle");

    store_start_is_pulse: assert property (@(posedge clock) disable iff (rst)
        store_start |=> !store_start)
        else report_failure("store_start stayed high for more than one cycle");

    initial begin
        #(400 * NUM_TESTS * CLK_PERIOD);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        lfsr = 32'h0c87_de07;
        rst = 1'b1;
        stall = 1'b0;
        is_stall = 1'b0;
        load_done = 1'b0;
        store_done = 1'b0;
        if_id_in = '0;
        cdb_in = '0;
        drv_accept = 1'b0;
        drv_entry = '0;
        exp_squash = 1'b0;
        prev_squash = 1'b0;
        cdb_en = 1'b1;
        force_mispred = 1'b0;
        hold_is_stall = 1'b0;
        squash_count = 0;
        store_count = 0;
        load_count = 0;
        flush_model();
        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;

        // quiet after reset
        check_value("is_out.valid", is_out.valid, 0);
        check_value("retire_out.valid", retire_out.valid, 0);
        check_value("store_start", store_start, 0);
        check_value("squash", squash, 0);
        check_value("mem_busy", mem_busy, 0);
        check_value("struc_hazard", struc_hazard, 0);
        repeat (5) step();

        // mixed traffic with random cdb order
        queue_random(40);
        run_until_idle();

        // station fills while issue is held
        hold_is_stall = 1'b1;
        cdb_en = 1'b0;
        for (int i = 0; i < 5; i++) begin
            prog.push_back(make_inst(`OP_ALU, reg_idx_t'(4 + i), 4'd8, 4'd9));
        end
        while (!struc_hazard) step();
        repeat (4) step();
        check_value("rs entries held", rs_cnt, `RS_DEPTH);
        check_value("instructions left in fetch", prog.size(), 1);
        hold_is_stall = 1'b0;
        cdb_en = 1'b1;
        run_until_idle();

        // rob fills behind an unfinished head
        cdb_en = 1'b0;
        prog.push_back(make_inst(`OP_ALU, 4'd1, 4'd2, 4'd3));
        for (int i = 0; i < 8; i++) begin
            prog.push_back(make_inst(`OP_NOP, 4'd0, 4'd0, 4'd0));
        end
        while (!struc_hazard) step();
        repeat (4) step();
        check_value("rob entries held", m_cnt, `ROB_DEPTH);
        check_value("instructions left in fetch", prog.size(), 1);
        cdb_en = 1'b1;
        run_until_idle();

        // mispredicted branch with younger work behind it
        squash_before = squash_count;
        force_mispred = 1'b1;
        prog.push_back(make_inst(`OP_BRANCH, 4'd0, 4'd1, 4'd2));
        prog.push_back(make_inst(`OP_ALU, 4'd3, 4'd1, 4'd1));
        prog.push_back(make_inst(`OP_ALU, 4'd4, 4'd3, 4'd2));
        prog.push_back(make_inst(`OP_LOAD, 4'd5, 4'd10, 4'd10));
        prog.push_back(make_inst(`OP_NOP, 4'd0, 4'd0, 4'd0));
        run_until_idle();
        force_mispred = 1'b0;
        assert (squash_count > squash_before) else begin
            report_failure("the mispredicted branch never raised squash");
        end

        // one memory operation at a time
        store_before = store_count;
        load_before = load_count;
        prog.push_back(make_inst(`OP_LOAD, 4'd5, 4'd1, 4'd1));
        prog.push_back(make_inst(`OP_STORE, 4'd0, 4'd5, 4'd2));
        prog.push_back(make_inst(`OP_ALU, 4'd6, 4'd5, 4'd5));
        prog.push_back(make_inst(`OP_STORE, 4'd0, 4'd6, 4'd1));
        run_until_idle();
        check_value("stores started", store_count - store_before, 2);
        check_value("loads completed", load_count - load_before, 1);

        repeat (3) step();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/ooo_pkg.sv
hw/decode_stage.sv
hw/map_table.sv
hw/reservation_station.sv
hw/reorder_buffer.sv
hw/dispatch_issue.sv
tb/dispatch_issue_tb.sv
